//--- id_stage.f
+incdir+logic
logic/id_stage_pkg.sv
logic/id_decoder.sv
logic/id_register_file.sv
logic/id_operand_mux.sv
logic/id_wb_ctrl.sv
logic/id_stage.sv
tb/id_stage_tb.sv

//--- logic/id_decoder.sv
`timescale 1ns/100ps
`default_nettype none
`include "id_stage_defs.svh"

module id_decoder (
	input  id_stage_pkg::instr_t    instr_i,
	output id_stage_pkg::dec_ctrl_t dec_o
);

	id_stage_pkg::opcode_e  opcode;
	id_stage_pkg::imm_sel_e imm_sel;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	logic                   reg_op;
	logic                   f7_zero;
	logic                   f7_alt;
	id_stage_pkg::word_t    imm_i_type;
	id_stage_pkg::word_t    imm_s_type;
	id_stage_pkg::word_t    imm_b_type;
	id_stage_pkg::word_t    imm_u_type;
	id_stage_pkg::word_t    imm_j_type;

	assign opcode  = id_stage_pkg::opcode_e'(instr_i[6:0]);
	assign funct3  = instr_i[14:12];
	assign funct7  = instr_i[31:25];
	assign reg_op  = (opcode == id_stage_pkg::OPCODE_OP);
	assign f7_zero = (funct7 == 7'h00);
	// SUB and SRA/SRAI encoding
	assign f7_alt  = (funct7 == 7'h20);

	////////////////////////////////////////
	// Immediates
	////////////////////////////////////////

	assign imm_i_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{(`ID_XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{(`ID_XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
		instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'h000};
	assign imm_j_type = {{(`ID_XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
		instr_i[20], instr_i[30:21], 1'b0};

	////////////////////////////////////////
	// Control decode
	////////////////////////////////////////

	always_comb begin
		dec_o             = '0;
		dec_o.rs1         = instr_i[19:15];
		dec_o.rs2         = instr_i[24:20];
		dec_o.rd          = instr_i[11:7];
		dec_o.alu_op      = id_stage_pkg::ALU_ADD;
		dec_o.op_a_sel    = id_stage_pkg::OP_A_REG_A;
		dec_o.op_b_sel    = id_stage_pkg::OP_B_IMM;
		dec_o.instr_class = id_stage_pkg::CLASS_ALU;
		imm_sel           = id_stage_pkg::IMM_I;

		case (opcode)
			id_stage_pkg::OPCODE_LUI: begin
				dec_o.op_a_sel = id_stage_pkg::OP_A_ZERO;
				dec_o.rf_we    = 1'b1;
				imm_sel        = id_stage_pkg::IMM_U;
			end
			id_stage_pkg::OPCODE_AUIPC: begin
				dec_o.op_a_sel = id_stage_pkg::OP_A_CURR_PC;
				dec_o.rf_we    = 1'b1;
				imm_sel        = id_stage_pkg::IMM_U;
			end
			id_stage_pkg::OPCODE_JAL: begin
				// Link value only, target is computed downstream
				dec_o.op_a_sel = id_stage_pkg::OP_A_CURR_PC;
				dec_o.op_b_sel = id_stage_pkg::OP_B_INCR_PC;
				dec_o.rf_we    = 1'b1;
				imm_sel        = id_stage_pkg::IMM_J;
			end
			id_stage_pkg::OPCODE_LOAD: begin
				dec_o.instr_class = id_stage_pkg::CLASS_LOAD;
				dec_o.rf_we       = 1'b1;
				dec_o.illegal     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
			end
			id_stage_pkg::OPCODE_STORE: begin
				dec_o.instr_class = id_stage_pkg::CLASS_STORE;
				dec_o.illegal     = funct3[2] || (funct3[1:0] == 2'b11);
				imm_sel           = id_stage_pkg::IMM_S;
			end
			id_stage_pkg::OPCODE_OP_IMM, id_stage_pkg::OPCODE_OP: begin
				dec_o.rf_we = 1'b1;
				if (reg_op) begin
					dec_o.op_b_sel = id_stage_pkg::OP_B_REG_B;
				end
				case (funct3)
					3'b000: begin
						if (reg_op && f7_alt) begin
							dec_o.alu_op = id_stage_pkg::ALU_SUB;
						end
					end
					3'b001: dec_o.alu_op = id_stage_pkg::ALU_SLL;
					3'b010: dec_o.alu_op = id_stage_pkg::ALU_SLT;
					3'b011: dec_o.alu_op = id_stage_pkg::ALU_SLTU;
					3'b100: dec_o.alu_op = id_stage_pkg::ALU_XOR;
					3'b101: begin
						dec_o.alu_op = id_stage_pkg::ALU_SRL;
						if (f7_alt) begin
							dec_o.alu_op = id_stage_pkg::ALU_SRA;
						end
					end
					3'b110: dec_o.alu_op = id_stage_pkg::ALU_OR;
					default: dec_o.alu_op = id_stage_pkg::ALU_AND;
				endcase
				// funct7 is checked for register ops and shift immediates
				if (reg_op || funct3 == 3'b001 || funct3 == 3'b101) begin
					dec_o.illegal = !(f7_zero || (f7_alt &&
						(funct3 == 3'b101 || (reg_op && funct3 == 3'b000))));
				end
			end
			id_stage_pkg::OPCODE_BRANCH: begin
				dec_o.op_b_sel    = id_stage_pkg::OP_B_REG_B;
				dec_o.instr_class = id_stage_pkg::CLASS_BRANCH;
				imm_sel           = id_stage_pkg::IMM_B;
				case (funct3)
					3'b000: dec_o.alu_op = id_stage_pkg::ALU_EQ;
					3'b001: dec_o.alu_op = id_stage_pkg::ALU_NE;
					3'b100: dec_o.alu_op = id_stage_pkg::ALU_LT;
					3'b101: dec_o.alu_op = id_stage_pkg::ALU_GE;
					3'b110: dec_o.alu_op = id_stage_pkg::ALU_LTU;
					3'b111: dec_o.alu_op = id_stage_pkg::ALU_GEU;
					default: dec_o.illegal = 1'b1;
				endcase
			end
			// JALR, MISC_MEM, SYSTEM and anything unknown
			default: dec_o.illegal = 1'b1;
		endcase

		if (dec_o.illegal) begin
			dec_o.rf_we = 1'b0;
		end

		case (imm_sel)
			id_stage_pkg::IMM_S: dec_o.imm = imm_s_type;
			id_stage_pkg::IMM_B: dec_o.imm = imm_b_type;
			id_stage_pkg::IMM_U: dec_o.imm = imm_u_type;
			id_stage_pkg::IMM_J: dec_o.imm = imm_j_type;
			default: dec_o.imm = imm_i_type;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/id_operand_mux.sv
`timescale 1ns/100ps
`default_nettype none
`include "id_stage_defs.svh"

module id_operand_mux (
	input  id_stage_pkg::dec_ctrl_t dec_i,
	input  id_stage_pkg::word_t     pc_i,
	input  id_stage_pkg::word_t     rdata_a_i,
	input  id_stage_pkg::word_t     rdata_b_i,
	output id_stage_pkg::word_t     operand_a_o,
	output id_stage_pkg::word_t     operand_b_o,
	output id_stage_pkg::word_t     data_wdata_o
);

	always_comb begin
		case (dec_i.op_a_sel)
			id_stage_pkg::OP_A_CURR_PC: operand_a_o = pc_i;
			id_stage_pkg::OP_A_ZERO: operand_a_o = '0;
			default: operand_a_o = rdata_a_i;
		endcase
	end

	always_comb begin
		case (dec_i.op_b_sel)
			id_stage_pkg::OP_B_IMM: operand_b_o = dec_i.imm;
			// Link address offset for JAL
			id_stage_pkg::OP_B_INCR_PC: operand_b_o = id_stage_pkg::word_t'(`ID_IMM_INCR_PC);
			default: operand_b_o = rdata_b_i;
		endcase
	end

	// Store data always comes from rs2
	assign data_wdata_o = rdata_b_i;

endmodule

`default_nettype wire

//--- logic/id_register_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "id_stage_defs.svh"

module id_register_file (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  id_stage_pkg::reg_addr_t raddr_a_i,
	input  id_stage_pkg::reg_addr_t raddr_b_i,
	input  id_stage_pkg::reg_addr_t waddr_i,
	input  id_stage_pkg::word_t     wdata_i,
	input  logic                    we_i,
	output id_stage_pkg::word_t     rdata_a_o,
	output id_stage_pkg::word_t     rdata_b_o
);

	// No storage behind x0
	id_stage_pkg::word_t regs_q [1:`ID_NUM_REGS-1];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int i = 1; i < `ID_NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

	// Writeback control must already filter out rd == x0
	assert property (@(posedge clk_i) disable iff (!rst_ni) we_i |-> waddr_i != '0)
		else $error("register file write to x0");

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  instr_valid_i,
	input  id_stage_pkg::instr_t  instr_i,
	input  id_stage_pkg::word_t   pc_i,
	output logic                  id_in_ready_o,
	output id_stage_pkg::ex_req_t ex_req_o,
	input  id_stage_pkg::ex_rsp_t ex_rsp_i,
	output id_stage_pkg::retire_t retire_o,
	output logic                  illegal_insn_o
);

	id_stage_pkg::dec_ctrl_t dec;
	id_stage_pkg::word_t     rdata_a;
	id_stage_pkg::word_t     rdata_b;
	id_stage_pkg::word_t     operand_a;
	id_stage_pkg::word_t     operand_b;
	id_stage_pkg::word_t     data_wdata;
	id_stage_pkg::reg_addr_t rf_waddr;
	id_stage_pkg::word_t     rf_wdata;
	logic                    rf_we;

	id_decoder u_decoder (
		.instr_i (instr_i),
		.dec_o   (dec)
	);

	id_register_file u_register_file (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.raddr_a_i (dec.rs1),
		.raddr_b_i (dec.rs2),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata),
		.we_i      (rf_we),
		.rdata_a_o (rdata_a),
		.rdata_b_o (rdata_b)
	);

	id_operand_mux u_operand_mux (
		.dec_i        (dec),
		.pc_i         (pc_i),
		.rdata_a_i    (rdata_a),
		.rdata_b_i    (rdata_b),
		.operand_a_o  (operand_a),
		.operand_b_o  (operand_b),
		.data_wdata_o (data_wdata)
	);

	id_wb_ctrl u_wb_ctrl (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.instr_valid_i  (instr_valid_i),
		.dec_i          (dec),
		.operand_a_i    (operand_a),
		.operand_b_i    (operand_b),
		.data_wdata_i   (data_wdata),
		.ex_rsp_i       (ex_rsp_i),
		.ex_req_o       (ex_req_o),
		.rf_waddr_o     (rf_waddr),
		.rf_wdata_o     (rf_wdata),
		.rf_we_o        (rf_we),
		.id_in_ready_o  (id_in_ready_o),
		.retire_o       (retire_o),
		.illegal_insn_o (illegal_insn_o)
	);

	// Stalled instruction must be held by the sender
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		instr_valid_i && !id_in_ready_o |=> $stable(instr_i) && $stable(pc_i))
		else $error("instruction changed while stalled");

endmodule

`default_nettype wire

//--- logic/id_stage_defs.svh
`ifndef ID_STAGE_DEFS_SVH
`define ID_STAGE_DEFS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Data word, address and PC width
`define ID_XLEN 32

////////////////////////////////////////
// Register file
////////////////////////////////////////

`define ID_NUM_REGS 32
`define ID_REG_ADDR_W 5

// Link increment for JAL, no compressed instructions
`define ID_IMM_INCR_PC 4

`endif

//--- logic/id_stage_pkg.sv
`default_nettype none
`include "id_stage_defs.svh"

package id_stage_pkg;

	typedef logic [`ID_XLEN-1:0] word_t;
	typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [31:0] instr_t;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	typedef enum logic [6:0] {
		OPCODE_LOAD   = 7'h03,
		OPCODE_OP_IMM = 7'h13,
		OPCODE_AUIPC  = 7'h17,
		OPCODE_STORE  = 7'h23,
		OPCODE_OP     = 7'h33,
		OPCODE_LUI    = 7'h37,
		OPCODE_BRANCH = 7'h63,
		OPCODE_JAL    = 7'h6f
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'h0,
		ALU_SUB  = 5'h1,
		ALU_XOR  = 5'h2,
		ALU_OR   = 5'h3,
		ALU_AND  = 5'h4,
		ALU_SRA  = 5'h5,
		ALU_SRL  = 5'h6,
		ALU_SLL  = 5'h7,
		// Branch compares
		ALU_LT   = 5'h8,
		ALU_LTU  = 5'h9,
		ALU_GE   = 5'ha,
		ALU_GEU  = 5'hb,
		ALU_EQ   = 5'hc,
		ALU_NE   = 5'hd,
		ALU_SLT  = 5'he,
		ALU_SLTU = 5'hf
	} alu_op_e;

	typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURR_PC, OP_A_ZERO} op_a_sel_e;
	typedef enum logic [1:0] {OP_B_REG_B, OP_B_IMM, OP_B_INCR_PC} op_b_sel_e;
	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
	typedef enum logic [1:0] {CLASS_ALU, CLASS_LOAD, CLASS_STORE, CLASS_BRANCH} instr_class_e;
	typedef enum logic {WB_IDLE = 1'b0, WB_WAIT_RSP = 1'b1} wb_state_e;

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////

	typedef struct packed {
		reg_addr_t    rs1;
		reg_addr_t    rs2;
		reg_addr_t    rd;
		alu_op_e      alu_op;
		op_a_sel_e    op_a_sel;
		op_b_sel_e    op_b_sel;
		word_t        imm;
		instr_class_e instr_class;
		logic         rf_we;
		logic         illegal;
	} dec_ctrl_t;

	typedef struct packed {
		logic    valid;
		logic    start;
		alu_op_e alu_op;
		word_t   operand_a;
		word_t   operand_b;
		logic    data_req;
		logic    data_we;
		word_t   data_wdata;
	} ex_req_t;

	typedef struct packed {
		logic  valid;
		word_t result;
		logic  taken;
		logic  err;
	} ex_rsp_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     wdata;
		logic      we;
		logic      branch;
		logic      taken;
	} retire_t;

endpackage

`default_nettype wire

//--- logic/id_wb_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module id_wb_ctrl (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    instr_valid_i,
	input  id_stage_pkg::dec_ctrl_t dec_i,
	input  id_stage_pkg::word_t     operand_a_i,
	input  id_stage_pkg::word_t     operand_b_i,
	input  id_stage_pkg::word_t     data_wdata_i,
	input  id_stage_pkg::ex_rsp_t   ex_rsp_i,
	output id_stage_pkg::ex_req_t   ex_req_o,
	output id_stage_pkg::reg_addr_t rf_waddr_o,
	output id_stage_pkg::word_t     rf_wdata_o,
	output logic                    rf_we_o,
	output logic                    id_in_ready_o,
	output id_stage_pkg::retire_t   retire_o,
	output logic                    illegal_insn_o
);

	id_stage_pkg::wb_state_e state_q;
	id_stage_pkg::wb_state_e state_d;
	logic                    issue;
	logic                    done;
	logic                    load_err;
	logic                    is_branch;
	logic                    is_mem;

	// Legal instruction on the input
	assign issue          = instr_valid_i && !dec_i.illegal;
	assign done           = issue && ex_rsp_i.valid;
	assign illegal_insn_o = instr_valid_i && dec_i.illegal;

	assign is_branch = (dec_i.instr_class == id_stage_pkg::CLASS_BRANCH);
	assign is_mem    = (dec_i.instr_class == id_stage_pkg::CLASS_LOAD) ||
		(dec_i.instr_class == id_stage_pkg::CLASS_STORE);
	assign load_err  = (dec_i.instr_class == id_stage_pkg::CLASS_LOAD) && ex_rsp_i.err;

	// Illegal instructions complete at once, legal ones on the response
	assign id_in_ready_o = !instr_valid_i || dec_i.illegal || ex_rsp_i.valid;

	////////////////////////////////////////
	// Wait FSM
	////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			id_stage_pkg::WB_IDLE: begin
				if (issue && !ex_rsp_i.valid) begin
					state_d = id_stage_pkg::WB_WAIT_RSP;
				end
			end
			id_stage_pkg::WB_WAIT_RSP: begin
				if (ex_rsp_i.valid) begin
					state_d = id_stage_pkg::WB_IDLE;
				end
			end
			default: state_d = id_stage_pkg::WB_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= id_stage_pkg::WB_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		ex_req_o            = '0;
		ex_req_o.valid      = issue;
		ex_req_o.start      = issue && (state_q == id_stage_pkg::WB_IDLE);
		ex_req_o.alu_op     = dec_i.alu_op;
		ex_req_o.operand_a  = operand_a_i;
		ex_req_o.operand_b  = operand_b_i;
		ex_req_o.data_req   = issue && is_mem;
		ex_req_o.data_we    = issue && (dec_i.instr_class == id_stage_pkg::CLASS_STORE);
		ex_req_o.data_wdata = data_wdata_i;
	end

	////////////////////////////////////////
	// Writeback and retire
	////////////////////////////////////////

	assign rf_we_o    = done && dec_i.rf_we && !load_err && (dec_i.rd != '0);
	assign rf_waddr_o = dec_i.rd;
	assign rf_wdata_o = ex_rsp_i.result;

	always_comb begin
		retire_o        = '0;
		retire_o.valid  = done;
		retire_o.rd     = dec_i.rd;
		retire_o.wdata  = ex_rsp_i.result;
		retire_o.we     = rf_we_o;
		retire_o.branch = done && is_branch;
		retire_o.taken  = done && is_branch && ex_rsp_i.taken;
	end

	// One outstanding request, the execute unit never answers unasked
	assert property (@(posedge clk_i) disable iff (!rst_ni) ex_rsp_i.valid |-> ex_req_o.valid)
		else $error("execute response without a pending request");

endmodule

`default_nettype wire

//--- tb/id_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "id_stage_defs.svh"

module id_stage_tb;

	// About 35 instructions of at most 5 cycles each, plus reset
	localparam int MAX_CYCLES = 2000;

	logic                  clk_i;
	logic                  rst_ni;
	logic                  instr_valid_i;
	id_stage_pkg::instr_t  instr_i;
	id_stage_pkg::word_t   pc_i;
	logic                  id_in_ready_o;
	id_stage_pkg::ex_req_t ex_req_o;
	id_stage_pkg::ex_rsp_t ex_rsp_i;
	id_stage_pkg::retire_t retire_o;
	logic                  illegal_insn_o;

	id_stage_pkg::word_t   ref_regs [`ID_NUM_REGS];
	id_stage_pkg::word_t   cur_pc;
	id_stage_pkg::ex_req_t last_req;
	integer                seed = 32'h6900_24ce;
	int                    cycles = 0;

	id_stage u_dut (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.instr_valid_i  (instr_valid_i),
		.instr_i        (instr_i),
		.pc_i           (pc_i),
		.id_in_ready_o  (id_in_ready_o),
		.ex_req_o       (ex_req_o),
		.ex_rsp_i       (ex_rsp_i),
		.retire_o       (retire_o),
		.illegal_insn_o (illegal_insn_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			stop_run();
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	task automatic stop_run();
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input id_stage_pkg::word_t exp,
			input id_stage_pkg::word_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_req(input string name, input id_stage_pkg::ex_req_t exp,
			input id_stage_pkg::ex_req_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected req %h, actual req %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_retire(input string name, input id_stage_pkg::retire_t exp,
			input id_stage_pkg::retire_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected retire %h, actual retire %h", name, exp, act);
			stop_run();
		end
	endtask

	////////////////////////////////////////
	// Encoders and execute model
	////////////////////////////////////////

	function automatic id_stage_pkg::word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic id_stage_pkg::instr_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic id_stage_pkg::instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic id_stage_pkg::instr_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic id_stage_pkg::instr_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic id_stage_pkg::instr_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic id_stage_pkg::instr_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic id_stage_pkg::ex_req_t make_req(input id_stage_pkg::alu_op_e op,
			input id_stage_pkg::word_t a, input id_stage_pkg::word_t b,
			input logic mem, input logic store);
		id_stage_pkg::ex_req_t r;
		r = '0;
		r.alu_op = op;
		r.operand_a = a;
		r.operand_b = b;
		r.data_req = mem;
		r.data_we = store;
		return r;
	endfunction

	function automatic id_stage_pkg::ex_rsp_t exec_model(input id_stage_pkg::alu_op_e op,
			input id_stage_pkg::word_t a, input id_stage_pkg::word_t b);
		id_stage_pkg::ex_rsp_t rsp;
		rsp = '0;
		rsp.valid = 1'b1;
		case (op)
			id_stage_pkg::ALU_ADD: rsp.result = a + b;
			id_stage_pkg::ALU_SUB: rsp.result = a - b;
			id_stage_pkg::ALU_XOR: rsp.result = a ^ b;
			id_stage_pkg::ALU_OR: rsp.result = a | b;
			id_stage_pkg::ALU_AND: rsp.result = a & b;
			id_stage_pkg::ALU_SRA: rsp.result = $signed(a) >>> b[4:0];
			id_stage_pkg::ALU_SRL: rsp.result = a >> b[4:0];
			id_stage_pkg::ALU_SLL: rsp.result = a << b[4:0];
			id_stage_pkg::ALU_SLT: rsp.result = id_stage_pkg::word_t'($signed(a) < $signed(b));
			id_stage_pkg::ALU_SLTU: rsp.result = id_stage_pkg::word_t'(a < b);
			// Compares leave result at zero
			id_stage_pkg::ALU_LT: rsp.taken = $signed(a) < $signed(b);
			id_stage_pkg::ALU_LTU: rsp.taken = a < b;
			id_stage_pkg::ALU_GE: rsp.taken = $signed(a) >= $signed(b);
			id_stage_pkg::ALU_GEU: rsp.taken = a >= b;
			id_stage_pkg::ALU_EQ: rsp.taken = a == b;
			id_stage_pkg::ALU_NE: rsp.taken = a != b;
			default: rsp.result = '0;
		endcase
		return rsp;
	endfunction

	////////////////////////////////////////
	// Instruction drivers
	////////////////////////////////////////

	// Present one instruction, answer after delay cycles, check every cycle
	task automatic run_instr(input string name, input id_stage_pkg::instr_t instr,
			input int delay, input id_stage_pkg::ex_req_t req, input logic wr,
			input logic is_branch, input logic err);
		id_stage_pkg::ex_req_t exp_req;
		id_stage_pkg::ex_rsp_t rsp;
		id_stage_pkg::retire_t exp_ret;
		id_stage_pkg::reg_addr_t rd;
		rd = instr[11:7];
		exp_req = req;
		exp_req.valid = 1'b1;
		// Store data port carries the register named by the rs2 field
		exp_req.data_wdata = ref_regs[instr[24:20]];
		rsp = exec_model(req.alu_op, req.operand_a, req.operand_b);
		rsp.err = err;
		exp_ret = '0;
		exp_ret.valid = 1'b1;
		exp_ret.rd = rd;
		exp_ret.wdata = rsp.result;
		exp_ret.we = wr && !err && (rd != '0);
		exp_ret.branch = is_branch;
		exp_ret.taken = is_branch && rsp.taken;

		@(negedge clk_i);
		instr_valid_i = 1'b1;
		instr_i = instr;
		pc_i = cur_pc;
		for (int cyc = 0; cyc < delay; cyc++) begin
			#2;
			exp_req.start = (cyc == 0);
			check_req(name, exp_req, ex_req_o);
			check_bit(name, 1'b0, id_in_ready_o);
			check_bit(name, 1'b0, retire_o.valid);
			@(negedge clk_i);
		end
		ex_rsp_i = rsp;
		#2;
		exp_req.start = (delay == 0);
		check_req(name, exp_req, ex_req_o);
		check_bit(name, 1'b1, id_in_ready_o);
		check_bit(name, 1'b0, illegal_insn_o);
		check_retire(name, exp_ret, retire_o);
		last_req = ex_req_o;

		@(negedge clk_i);
		instr_valid_i = 1'b0;
		ex_rsp_i = '0;
		#2;
		check_bit(name, 1'b0, retire_o.valid);
		check_bit(name, 1'b0, ex_req_o.valid);
		if (exp_ret.we) begin
			ref_regs[rd] = rsp.result;
		end
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic run_r(input string name, input logic [6:0] f7, input logic [2:0] f3,
			input id_stage_pkg::alu_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input int delay);
		run_instr(name, enc_r(f7, rs2, rs1, f3, rd), delay,
			make_req(op, ref_regs[rs1], ref_regs[rs2], 1'b0, 1'b0), 1'b1, 1'b0, 1'b0);
	endtask

	task automatic run_addi(input string name, input logic [4:0] rd, input logic [11:0] imm);
		run_instr(name, enc_i(imm, 5'd0, 3'b000, rd, 7'h13), 0,
			make_req(id_stage_pkg::ALU_ADD, '0, sext12(imm), 1'b0, 1'b0), 1'b1, 1'b0, 1'b0);
	endtask

	task automatic run_branch(input string name, input logic [2:0] f3,
			input id_stage_pkg::alu_op_e op, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [12:0] offs;
		int delay;
		offs = $random(seed);
		offs[0] = 1'b0;
		delay = {$random(seed)} % 4;
		run_instr(name, enc_b(offs, rs2, rs1, f3), delay,
			make_req(op, ref_regs[rs1], ref_regs[rs2], 1'b0, 1'b0), 1'b0, 1'b1, 1'b0);
	endtask

	task automatic check_illegal(input string name, input id_stage_pkg::instr_t instr);
		@(negedge clk_i);
		instr_valid_i = 1'b1;
		instr_i = instr;
		pc_i = cur_pc;
		#2;
		check_bit(name, 1'b1, illegal_insn_o);
		check_bit(name, 1'b1, id_in_ready_o);
		check_bit(name, 1'b0, ex_req_o.valid);
		check_bit(name, 1'b0, retire_o.valid);
		@(negedge clk_i);
		instr_valid_i = 1'b0;
		#2;
		check_bit(name, 1'b0, illegal_insn_o);
		cur_pc = cur_pc + 32'd4;
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_alu_reg();
		logic [11:0] imm;
		for (int r = 1; r <= 5; r++) begin
			imm = $random(seed);
			run_addi("alu_reg addi", 5'(r), imm);
		end
		run_r("alu_reg add", 7'h00, 3'b000, id_stage_pkg::ALU_ADD, 5'd6, 5'd1, 5'd2, 0);
		run_r("alu_reg sub", 7'h20, 3'b000, id_stage_pkg::ALU_SUB, 5'd7, 5'd3, 5'd4, 0);
		run_r("alu_reg xor", 7'h00, 3'b100, id_stage_pkg::ALU_XOR, 5'd8, 5'd5, 5'd1, 0);
		run_r("alu_reg or", 7'h00, 3'b110, id_stage_pkg::ALU_OR, 5'd9, 5'd2, 5'd3, 0);
		run_r("alu_reg and", 7'h00, 3'b111, id_stage_pkg::ALU_AND, 5'd10, 5'd4, 5'd5, 0);
		run_r("alu_reg slt", 7'h00, 3'b010, id_stage_pkg::ALU_SLT, 5'd11, 5'd1, 5'd3, 0);
		run_r("alu_reg sltu", 7'h00, 3'b011, id_stage_pkg::ALU_SLTU, 5'd12, 5'd2, 5'd4, 0);
		run_r("alu_reg sll", 7'h00, 3'b001, id_stage_pkg::ALU_SLL, 5'd13, 5'd5, 5'd2, 0);
		run_r("alu_reg srl", 7'h00, 3'b101, id_stage_pkg::ALU_SRL, 5'd14, 5'd3, 5'd1, 0);
		run_r("alu_reg sra", 7'h20, 3'b101, id_stage_pkg::ALU_SRA, 5'd15, 5'd4, 5'd5, 0);
	endtask

	task automatic test_imm_formats();
		logic [19:0] upper;
		logic [20:0] joffs;
		logic [11:0] soffs;
		id_stage_pkg::word_t link;
		upper = $random(seed);
		run_instr("imm lui", enc_u(upper, 5'd16, 7'h37), 0,
			make_req(id_stage_pkg::ALU_ADD, '0, {upper, 12'h000}, 1'b0, 1'b0),
			1'b1, 1'b0, 1'b0);
		upper = $random(seed);
		run_instr("imm auipc", enc_u(upper, 5'd17, 7'h17), 0,
			make_req(id_stage_pkg::ALU_ADD, cur_pc, {upper, 12'h000}, 1'b0, 1'b0),
			1'b1, 1'b0, 1'b0);
		joffs = $random(seed);
		joffs[0] = 1'b0;
		link = cur_pc + 32'd4;
		run_instr("imm jal", enc_j(joffs, 5'd18), 0,
			make_req(id_stage_pkg::ALU_ADD, cur_pc, 32'd4, 1'b0, 1'b0), 1'b1, 1'b0, 1'b0);
		// Store of the link register reads back what JAL wrote
		soffs = $random(seed);
		run_instr("imm store", enc_s(soffs, 5'd18, 5'd1, 3'b010), 0,
			make_req(id_stage_pkg::ALU_ADD, ref_regs[1], sext12(soffs), 1'b1, 1'b1),
			1'b0, 1'b0, 1'b0);
		check_word("imm jal link", link, last_req.data_wdata);
	endtask

	task automatic test_multicycle();
		run_r("multicycle add", 7'h00, 3'b000, id_stage_pkg::ALU_ADD, 5'd19, 5'd6, 5'd7, 3);
		run_r("multicycle xor", 7'h00, 3'b100, id_stage_pkg::ALU_XOR, 5'd20, 5'd19, 5'd8, 1);
	endtask

	task automatic test_branches();
		run_branch("branch beq taken", 3'b000, id_stage_pkg::ALU_EQ, 5'd1, 5'd1);
		run_branch("branch beq", 3'b000, id_stage_pkg::ALU_EQ, 5'd1, 5'd2);
		run_branch("branch bne", 3'b001, id_stage_pkg::ALU_NE, 5'd1, 5'd2);
		run_branch("branch blt", 3'b100, id_stage_pkg::ALU_LT, 5'd3, 5'd4);
		run_branch("branch bgeu", 3'b111, id_stage_pkg::ALU_GEU, 5'd4, 5'd3);
	endtask

	task automatic test_load_err_x0();
		logic [11:0] offs;
		id_stage_pkg::word_t old;
		offs = $random(seed);
		old = ref_regs[3];
		run_instr("load_err lw", enc_i(offs, 5'd1, 3'b010, 5'd3, 7'h03), 2,
			make_req(id_stage_pkg::ALU_ADD, ref_regs[1], sext12(offs), 1'b1, 1'b0),
			1'b1, 1'b0, 1'b1);
		run_r("load_err add", 7'h00, 3'b000, id_stage_pkg::ALU_ADD, 5'd21, 5'd3, 5'd0, 0);
		check_word("load_err old value", old, last_req.operand_a);
		offs = $random(seed);
		run_addi("x0 addi", 5'd0, offs);
		run_r("x0 read", 7'h00, 3'b000, id_stage_pkg::ALU_ADD, 5'd22, 5'd0, 5'd0, 0);
		check_word("x0 read", '0, last_req.operand_a);
	endtask

	task automatic test_illegal();
		check_illegal("illegal system", enc_i(12'h000, 5'd0, 3'b000, 5'd0, 7'h73));
		check_illegal("illegal jalr", enc_i(12'h010, 5'd1, 3'b000, 5'd5, 7'h67));
		// MUL is outside the supported set
		check_illegal("illegal mul", enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd6));
		run_r("illegal next", 7'h00, 3'b000, id_stage_pkg::ALU_ADD, 5'd23, 5'd1, 5'd2, 0);
	endtask

	initial begin
		foreach (ref_regs[i]) begin
			ref_regs[i] = '0;
		end
		cur_pc = 32'h0000_1000;
		last_req = '0;
		rst_ni = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		pc_i = '0;
		ex_rsp_i = '0;
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_ni = 1'b1;
		#2;
		check_bit("reset ready", 1'b1, id_in_ready_o);
		check_bit("reset req valid", 1'b0, ex_req_o.valid);
		check_bit("reset retire valid", 1'b0, retire_o.valid);

		test_alu_reg();
		test_imm_formats();
		test_multicycle();
		test_branches();
		test_load_err_x0();
		test_illegal();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
